//--- design/link_pkg.sv
// serial link constants and the word type shared by the UART and framing blocks
// the bit period is kept short for simulation and is not derived from a baud rate
// CLKS_PER_BIT is expected to be a power of two of at least 4
`default_nettype none

package link_pkg;

   // clock cycles per serial bit
   localparam int CLKS_PER_BIT = 8;

   // counter wide enough to hold 0 .. CLKS_PER_BIT-1
   localparam int BIT_CTR_W = $clog2(CLKS_PER_BIT);

   // stress word width, two bytes on the wire
   localparam int WORD_W = 16;

   // one word seen either whole or as two bytes
   // the controller counts and compares the whole word
   // the framer sends and gathers the byte halves
   typedef union packed {
      logic [WORD_W-1:0] word;
      struct packed {
         logic [7:0] hi;
         logic [7:0] lo;
      } bytes;
   } link_word_t;

endpackage

`default_nettype wire

//--- design/stress_pkg.sv
// stress controller state encoding and in-flight limits
// MAX_OUTSTANDING bounds how many words may be on the wire before an echo returns
`default_nettype none

package stress_pkg;

   // controller states
   typedef enum logic [1:0] {
      IDLE,
      ISSUE,
      WAIT_ACCEPT,
      HOLD
   } ctrl_state_t;

   // words sent but not yet echoed back
   localparam int MAX_OUTSTANDING = 4;

   // in-flight counter has to reach MAX_OUTSTANDING itself
   localparam int OUTSTANDING_W = $clog2(MAX_OUTSTANDING + 1);

endpackage

`default_nettype wire

//--- design/baud_timer.sv
// bit-period timer for one serial block
// counts only while run is high, restart takes priority and reloads to zero
// mid_tick and end_tick are combinational from the count
`timescale 1ns/1ps
`default_nettype none

module baud_timer (
   input  logic clk,
   input  logic rst,
   input  logic restart,
   input  logic run,
   output logic mid_tick,
   output logic end_tick
);

   logic [link_pkg::BIT_CTR_W-1:0] cnt;

   always_ff @(posedge clk) begin
      if (rst || restart) begin
         cnt <= '0;
      end else if (run) begin
         // wraps at the end of the bit, next bit starts at zero
         if (end_tick) begin
            cnt <= '0;
         end else begin
            cnt <= cnt + (link_pkg::BIT_CTR_W)'(1);
         end
      end
   end

   // halfway point for sampling
   assign mid_tick = run && (cnt == (link_pkg::BIT_CTR_W)'(link_pkg::CLKS_PER_BIT / 2 - 1));
   // last cycle of the bit
   assign end_tick = run && (cnt == (link_pkg::BIT_CTR_W)'(link_pkg::CLKS_PER_BIT - 1));

   // a restart comes only between frames, never inside a running bit
   a_restart_idle: assert property (@(posedge clk) disable iff (rst)
      !(restart && run));

endmodule

`default_nettype wire

//--- design/uart_rx.sv
// 8N1 receiver, no parity and no buffering
// a start bit that is high again at its midpoint is dropped as a glitch
// rx_byte is valid only in the cycle of rx_done
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
   input  logic       clk,
   input  logic       rst,
   input  logic       rx,
   output logic [7:0] rx_byte,
   output logic       rx_done,
   output logic       rx_frame_err
);

   logic       rx_s1;
   logic       rx_s2;
   logic       rx_q;
   logic       active;
   logic [3:0] bit_idx;
   logic [7:0] shreg;
   logic       start_edge;
   logic       mid_tick;

   // falling edge on the synchronized line while no frame is running
   assign start_edge = !active && rx_q && !rx_s2;

   baud_timer timer_inst (
      .clk      (clk),
      .rst      (rst),
      .restart  (start_edge),
      .run      (active),
      .mid_tick (mid_tick),
      .end_tick ()
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         // line idles high
         rx_s1        <= 1'b1;
         rx_s2        <= 1'b1;
         rx_q         <= 1'b1;
         active       <= 1'b0;
         bit_idx      <= '0;
         rx_done      <= 1'b0;
         rx_frame_err <= 1'b0;
      end else begin
         // two-flop synchronizer plus one stage for edge detect
         rx_s1        <= rx;
         rx_s2        <= rx_s1;
         rx_q         <= rx_s2;
         rx_done      <= 1'b0;
         rx_frame_err <= 1'b0;
         if (start_edge) begin
            active  <= 1'b1;
            bit_idx <= '0;
         end else if (active && mid_tick) begin
            bit_idx <= bit_idx + 4'd1;
            if (bit_idx == 4'd0) begin
               // start bit must still be low at its centre
               if (rx_s2) begin
                  active <= 1'b0;
               end
            end else if (bit_idx == 4'd9) begin
               // stop bit centre, frame ends here
               active       <= 1'b0;
               rx_done      <= rx_s2;
               rx_frame_err <= !rx_s2;
            end
         end
      end
   end

   // data bits arrive lsb first, shift in from the top
   always_ff @(posedge clk) begin
      if (active && mid_tick && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
         shreg <= {rx_s2, shreg[7:1]};
      end
   end

   assign rx_byte = shreg;

endmodule

`default_nettype wire

//--- design/uart_tx.sv
// 8N1 transmitter with hardware flow control
// cts_n is looked at only before the start bit, a running byte always completes
// tx_start must not be pulsed while tx_busy is high
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
   input  logic       clk,
   input  logic       rst,
   input  logic       cts_n,
   input  logic [7:0] tx_byte,
   input  logic       tx_start,
   output logic       tx_busy,
   output logic       tx
);

   logic       sending;
   logic [3:0] bit_idx;
   logic [7:0] shreg;
   logic       launch;
   logic       end_tick;

   // byte latched and host ready, begin the start bit
   assign launch = tx_busy && !sending && !cts_n;

   baud_timer timer_inst (
      .clk      (clk),
      .rst      (rst),
      .restart  (launch),
      .run      (sending),
      .mid_tick (),
      .end_tick (end_tick)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         tx_busy <= 1'b0;
         sending <= 1'b0;
         bit_idx <= '0;
         tx      <= 1'b1;
      end else begin
         if (tx_start && !tx_busy) begin
            tx_busy <= 1'b1;
         end
         if (launch) begin
            sending <= 1'b1;
            bit_idx <= '0;
            tx      <= 1'b0;
         end else if (sending && end_tick) begin
            if (bit_idx == 4'd9) begin
               // end of stop bit
               tx_busy <= 1'b0;
               sending <= 1'b0;
            end else begin
               // data bits then the stop bit, which is the shifted-in one
               tx      <= shreg[0];
               bit_idx <= bit_idx + 4'd1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (tx_start && !tx_busy) begin
         shreg <= tx_byte;
      end else if (sending && end_tick && bit_idx != 4'd9) begin
         shreg <= {1'b1, shreg[7:1]};
      end
   end

   // the framer waits for the previous byte before starting another
   a_no_start_when_busy: assert property (@(posedge clk) disable iff (rst)
      tx_start |-> !tx_busy);

endmodule

`default_nettype wire

//--- design/word_framer.sv
// splits words into two bytes and joins byte pairs back into words
// low byte goes first in both directions
// the receive side has no resync, a lost byte shifts the pairing
`timescale 1ns/1ps
`default_nettype none

module word_framer (
   input  logic                 clk,
   input  logic                 rst,
   input  link_pkg::link_word_t tx_word,
   input  logic                 tx_valid,
   output logic                 tx_ready,
   output logic [7:0]           tx_byte,
   output logic                 tx_start,
   input  logic                 tx_busy,
   input  logic [7:0]           rx_byte,
   input  logic                 rx_done,
   output link_pkg::link_word_t rx_word,
   output logic                 rx_valid
);

   logic       tx_pend;
   logic       tx_hi_phase;
   logic [7:0] hi_hold;
   logic       byte_done;
   logic       rx_half;
   logic [7:0] lo_hold;

   // new word only when both bytes of the last one are out
   assign tx_ready = !tx_pend;

   // tx_busy rises the cycle after tx_start, so skip that cycle
   assign byte_done = tx_pend && !tx_start && !tx_busy;

   always_ff @(posedge clk) begin
      if (rst) begin
         tx_pend     <= 1'b0;
         tx_hi_phase <= 1'b0;
         tx_start    <= 1'b0;
         rx_half     <= 1'b0;
         rx_valid    <= 1'b0;
      end else begin
         tx_start <= 1'b0;
         rx_valid <= 1'b0;
         if (tx_valid && tx_ready) begin
            tx_pend     <= 1'b1;
            tx_hi_phase <= 1'b0;
            tx_start    <= 1'b1;
         end else if (byte_done) begin
            if (!tx_hi_phase) begin
               tx_hi_phase <= 1'b1;
               tx_start    <= 1'b1;
            end else begin
               tx_pend <= 1'b0;
            end
         end
         // second byte of a pair completes the word
         if (rx_done) begin
            rx_half  <= !rx_half;
            rx_valid <= rx_half;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (tx_valid && tx_ready) begin
         tx_byte <= tx_word.bytes.lo;
         hi_hold <= tx_word.bytes.hi;
      end else if (byte_done && !tx_hi_phase) begin
         tx_byte <= hi_hold;
      end
      if (rx_done) begin
         if (!rx_half) begin
            lo_hold <= rx_byte;
         end else begin
            rx_word.bytes.hi <= rx_byte;
            rx_word.bytes.lo <= lo_hold;
         end
      end
   end

endmodule

`default_nettype wire

//--- design/stress_ctrl.sv
// issues an ascending word sequence and checks the echoed words in order
// error is sticky until reset and also flags framing faults and unexpected words
// idle means nothing is in flight, not that the sequence has ended
`timescale 1ns/1ps
`default_nettype none

module stress_ctrl (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 stall,
   output link_pkg::link_word_t tx_word,
   output logic                 tx_valid,
   input  logic                 tx_ready,
   input  link_pkg::link_word_t rx_word,
   input  logic                 rx_valid,
   input  logic                 rx_frame_err,
   output logic                 error,
   output logic                 idle
);

   stress_pkg::ctrl_state_t                state;
   link_pkg::link_word_t                   send_cnt;
   logic [link_pkg::WORD_W-1:0]            exp_cnt;
   logic [stress_pkg::OUTSTANDING_W-1:0]   outstanding;
   logic [stress_pkg::OUTSTANDING_W-1:0]   out_next;
   logic                                   accept;
   logic                                   retire;
   logic                                   can_issue;

   assign accept = tx_valid && tx_ready;
   // an echo with nothing in flight is not counted down
   assign retire = rx_valid && (outstanding != '0);

   always_comb begin
      out_next = outstanding;
      if (accept && !retire) begin
         out_next = outstanding + (stress_pkg::OUTSTANDING_W)'(1);
      end else if (retire && !accept) begin
         out_next = outstanding - (stress_pkg::OUTSTANDING_W)'(1);
      end
   end

   // decided on the count after this cycle's accept and echo
   assign can_issue = !stall
      && (out_next < (stress_pkg::OUTSTANDING_W)'(stress_pkg::MAX_OUTSTANDING));

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= stress_pkg::IDLE;
         tx_valid    <= 1'b0;
         send_cnt    <= '0;
         exp_cnt     <= '0;
         outstanding <= '0;
         error       <= 1'b0;
      end else begin
         outstanding <= out_next;
         case (state)
            stress_pkg::IDLE: begin
               state <= can_issue ? stress_pkg::ISSUE : stress_pkg::HOLD;
            end
            stress_pkg::ISSUE: begin
               tx_valid <= 1'b1;
               state    <= stress_pkg::WAIT_ACCEPT;
            end
            stress_pkg::WAIT_ACCEPT: begin
               if (accept) begin
                  tx_valid      <= 1'b0;
                  send_cnt.word <= send_cnt.word + (link_pkg::WORD_W)'(1);
                  state         <= can_issue ? stress_pkg::ISSUE : stress_pkg::HOLD;
               end
            end
            stress_pkg::HOLD: begin
               // in-flight words keep draining here
               if (can_issue) begin
                  state <= stress_pkg::ISSUE;
               end
            end
            default: begin
               state <= stress_pkg::IDLE;
            end
         endcase
         // echoes come back in send order
         if (rx_valid) begin
            exp_cnt <= exp_cnt + (link_pkg::WORD_W)'(1);
            if (outstanding == '0 || rx_word.word != exp_cnt) begin
               error <= 1'b1;
            end
         end
         if (rx_frame_err) begin
            error <= 1'b1;
         end
      end
   end

   assign tx_word = send_cnt;
   assign idle    = (outstanding == '0);

   a_outstanding_limit: assert property (@(posedge clk) disable iff (rst)
      outstanding <= (stress_pkg::OUTSTANDING_W)'(stress_pkg::MAX_OUTSTANDING));

endmodule

`default_nettype wire

//--- design/stress_top.sv
// serial-link stress tester top level
// uart_rx is expected to carry back every byte sent on uart_tx
// cts_n is active low and comes from the host side
`timescale 1ns/1ps
`default_nettype none

module stress_top (
   input  logic clk,
   input  logic rst,
   input  logic uart_rx,
   input  logic cts_n,
   input  logic stall,
   output logic uart_tx,
   output logic error,
   output logic idle
);

   link_pkg::link_word_t tx_word;
   link_pkg::link_word_t rx_word;
   logic                 tx_valid;
   logic                 tx_ready;
   logic                 rx_valid;
   logic [7:0]           tx_byte;
   logic                 tx_start;
   logic                 tx_busy;
   logic [7:0]           rx_byte;
   logic                 rx_done;
   logic                 rx_frame_err;

   stress_ctrl stress_ctrl_inst (
      .clk          (clk),
      .rst          (rst),
      .stall        (stall),
      .tx_word      (tx_word),
      .tx_valid     (tx_valid),
      .tx_ready     (tx_ready),
      .rx_word      (rx_word),
      .rx_valid     (rx_valid),
      .rx_frame_err (rx_frame_err),
      .error        (error),
      .idle         (idle)
   );

   word_framer word_framer_inst (
      .clk      (clk),
      .rst      (rst),
      .tx_word  (tx_word),
      .tx_valid (tx_valid),
      .tx_ready (tx_ready),
      .tx_byte  (tx_byte),
      .tx_start (tx_start),
      .tx_busy  (tx_busy),
      .rx_byte  (rx_byte),
      .rx_done  (rx_done),
      .rx_word  (rx_word),
      .rx_valid (rx_valid)
   );

   uart_tx uart_tx_inst (
      .clk      (clk),
      .rst      (rst),
      .cts_n    (cts_n),
      .tx_byte  (tx_byte),
      .tx_start (tx_start),
      .tx_busy  (tx_busy),
      .tx       (uart_tx)
   );

   uart_rx uart_rx_inst (
      .clk          (clk),
      .rst          (rst),
      .rx           (uart_rx),
      .rx_byte      (rx_byte),
      .rx_done      (rx_done),
      .rx_frame_err (rx_frame_err)
   );

endmodule

`default_nettype wire

//--- bench/stress_tb.sv
// testbench for the serial-link stress tester, run from the project root
// every byte seen on uart_tx is decoded and sent back on uart_rx
// one word per vector can go back with bit 0 of its low byte flipped
// cts_n is held high in short random bursts for the whole run
`timescale 1ns/1ps
`default_nettype none

module stress_tb;

   localparam int BIT     = link_pkg::CLKS_PER_BIT;
   localparam int MAX_VEC = 16;
   localparam int NONE    = 'hffff;

   logic        clk;
   logic        rst;
   logic        rx_line;
   logic        cts_n;
   logic        stall;
   logic        uart_tx;
   logic        error;
   logic        idle;
   // six fields per vector, see the data file
   logic [15:0] vec_mem [0:MAX_VEC*6-1];
   logic [7:0]  echo_mem [0:255];
   logic [7:0]  wr_idx = 8'd0;
   logic [7:0]  rd_idx = 8'd0;
   int          cur_words;
   int          cur_stall_at;
   int          cur_stall_len;
   int          cur_corrupt = NONE;
   logic        cur_exp_err = 1'b0;
   logic        echo_hold = 1'b0;
   int          decoded_words;
   int          stall_starts;
   logic        dec_busy;
   logic        echo_busy;
   logic        cts_at_pos;
   logic        stall_at_pos;
   logic        saw_err;
   logic        flagged;
   int          limit_cycles = 0;
   int          cycle_cnt = 0;
   int          err_main = 0;
   int          err_dec = 0;
   int          err_echo = 0;
   int          err_mon = 0;

   stress_top stress_top_inst (
      .clk     (clk),
      .rst     (rst),
      .uart_rx (rx_line),
      .cts_n   (cts_n),
      .stall   (stall),
      .uart_tx (uart_tx),
      .error   (error),
      .idle    (idle)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // host holds cts_n high for short random bursts
   initial begin
      cts_n = 1'b0;
      void'($urandom(80421));
      forever begin
         repeat (60 + $urandom % 240) @(negedge clk);
         cts_n = 1'b1;
         repeat (1 + $urandom % 40) @(negedge clk);
         cts_n = 1'b0;
      end
   end

   // values the DUT saw at the last rising edge
   always @(posedge clk) begin
      cts_at_pos   <= cts_n;
      stall_at_pos <= stall;
   end

   // decode uart_tx, queue each byte for the echo and check the word sequence
   initial begin : decode_tx
      logic [7:0] b;
      logic [7:0] lo;
      logic       phase;
      decoded_words = 0;
      stall_starts  = 0;
      dec_busy      = 1'b0;
      phase         = 1'b0;
      forever begin
         @(negedge clk);
         while (uart_tx !== 1'b0) begin
            if (rst) begin
               decoded_words = 0;
               phase         = 1'b0;
            end
            @(negedge clk);
         end
         dec_busy = 1'b1;
         assert (cts_at_pos == 1'b0) else begin
            $display("start bit appeared on uart_tx while cts_n was high");
            err_dec++;
         end
         // a new word beginning while stall is high
         if (!phase && stall_at_pos) begin
            stall_starts++;
         end
         repeat (BIT / 2) @(negedge clk);
         assert (uart_tx == 1'b0) else begin
            $display("start bit on uart_tx ended before its midpoint");
            err_dec++;
         end
         for (int i = 0; i < 8; i++) begin
            repeat (BIT) @(negedge clk);
            b[i] = uart_tx;
         end
         repeat (BIT) @(negedge clk);
         assert (uart_tx == 1'b1) else begin
            $display("ERR uart_tx stop bit exp=%h got=%h", 1'b1, uart_tx);
            err_dec++;
         end
         echo_mem[wr_idx] = b;
         wr_idx = wr_idx + 8'd1;
         if (phase) begin
            // high byte closes the word, k-th word carries k
            assert ({b, lo} == decoded_words[15:0]) else begin
               $display("ERR tx_word exp=%h got=%h", decoded_words[15:0], {b, lo});
               err_dec++;
            end
            decoded_words++;
         end else begin
            lo = b;
         end
         phase    = !phase;
         dec_busy = 1'b0;
      end
   end

   task automatic send_byte(input logic [7:0] data);
      rx_line = 1'b0;
      repeat (BIT) @(negedge clk);
      for (int i = 0; i < 8; i++) begin
         rx_line = data[i];
         repeat (BIT) @(negedge clk);
      end
      rx_line = 1'b1;
      repeat (BIT) @(negedge clk);
   endtask

   // loopback, bytes go back in order unless echoes are withheld
   initial begin : echo_rx
      logic [7:0] b;
      int         nbytes;
      rx_line   = 1'b1;
      echo_busy = 1'b0;
      nbytes    = 0;
      forever begin
         @(negedge clk);
         while (rd_idx == wr_idx || echo_hold) begin
            if (rst) begin
               nbytes = 0;
            end
            @(negedge clk);
         end
         echo_busy = 1'b1;
         b = echo_mem[rd_idx];
         rd_idx = rd_idx + 8'd1;
         if (nbytes[0] == 1'b0 && nbytes / 2 == cur_corrupt) begin
            b[0] = !b[0];
            // all earlier words were clean
            assert (!error) else begin
               $display("ERR error exp=%h got=%h ahead of the corrupted word", 1'b0, error);
               err_echo++;
            end
         end
         send_byte(b);
         nbytes++;
         echo_busy = 1'b0;
      end
   end

   // error stays low on clean vectors and never drops once raised
   always @(negedge clk) begin
      if (rst) begin
         saw_err = 1'b0;
         flagged = 1'b0;
      end else if (!flagged) begin
         assert (!(error && !cur_exp_err)) else begin
            $display("ERR error exp=%h got=%h", 1'b0, error);
            err_mon++;
            flagged = 1'b1;
         end
         assert (!(saw_err && !error)) else begin
            $display("error flag dropped before the next reset");
            err_mon++;
            flagged = 1'b1;
         end
         if (error) begin
            saw_err = 1'b1;
         end
      end
   end

   task automatic report_counts(input int timeouts);
      $display("error counts: sequence %0d, echo %0d, status %0d, control %0d, timeout %0d",
               err_dec, err_echo, err_mon, err_main, timeouts);
   endtask

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (limit_cycles > 0 && cycle_cnt > limit_cycles) begin
         $display("timeout, the run did not finish within %0d cycles", limit_cycles);
         report_counts(1);
         $display("Finished with errors");
         $finish;
      end
   end

   task automatic run_vector(input int v);
      int base;
      int quiet;
      rst   = 1'b1;
      stall = 1'b0;
      @(negedge clk);
      cur_words     = int'(vec_mem[v*6]);
      cur_stall_at  = int'(vec_mem[v*6+1]);
      cur_stall_len = int'(vec_mem[v*6+2]);
      cur_corrupt   = int'(vec_mem[v*6+3]);
      cur_exp_err   = vec_mem[v*6+4][0];
      echo_hold     = vec_mem[v*6+5][0];
      repeat (9) @(negedge clk);
      assert (uart_tx && idle && !error) else begin
         $display("ERR reset uart_tx/idle/error exp=%h/%h/%h got=%h/%h/%h",
                  1'b1, 1'b1, 1'b0, uart_tx, idle, error);
         err_main++;
      end
      rst = 1'b0;
      if (echo_hold) begin
         // without echoes the controller stops at its in-flight limit
         while (decoded_words < stress_pkg::MAX_OUTSTANDING) @(negedge clk);
         repeat (10 * 2 * BIT * 10) @(negedge clk);
         assert (decoded_words == stress_pkg::MAX_OUTSTANDING && !idle) else begin
            $display("ERR words_sent exp=%h got=%h idle=%h",
                     stress_pkg::MAX_OUTSTANDING, decoded_words, idle);
            err_main++;
         end
         echo_hold = 1'b0;
      end
      if (cur_stall_at != NONE) begin
         while (decoded_words < cur_stall_at) @(negedge clk);
         stall = 1'b1;
         base  = stall_starts;
         repeat (cur_stall_len) @(negedge clk);
         // only the word already offered to the framer may still start
         assert (stall_starts - base <= 1) else begin
            $display("ERR words_started_in_stall exp<=%h got=%h", 1, stall_starts - base);
            err_main++;
         end
         assert (idle) else begin
            $display("ERR idle exp=%h got=%h at the end of the stall", 1'b1, idle);
            err_main++;
         end
         stall = 1'b0;
      end
      while (decoded_words < cur_words) @(negedge clk);
      // stop new words and let the ones in flight drain
      stall = 1'b1;
      quiet = 0;
      while (quiet < 4 * BIT) begin
         @(negedge clk);
         if (idle && uart_tx && !dec_busy && !echo_busy && rd_idx == wr_idx) begin
            quiet++;
         end else begin
            quiet = 0;
         end
      end
      assert (error == cur_exp_err) else begin
         $display("ERR error exp=%h got=%h at the end of vector %0d", cur_exp_err, error, v);
         err_main++;
      end
   endtask

   initial begin : run_all
      int num_vec;
      int budget;
      rst   = 1'b1;
      stall = 1'b0;
      $readmemh("bench/stress_vectors.txt", vec_mem);
      // three times the wire time of each word, plus stall, reset and settle margins
      num_vec = 0;
      budget  = 0;
      while (num_vec < MAX_VEC && vec_mem[num_vec*6] != 16'd0) begin
         budget = budget + int'(vec_mem[num_vec*6]) * 2 * 10 * BIT * 3;
         budget = budget + int'(vec_mem[num_vec*6+2]) + 3000;
         num_vec++;
      end
      limit_cycles = budget;
      for (int v = 0; v < num_vec; v++) begin
         run_vector(v);
      end
      report_counts(0);
      if (err_main + err_dec + err_echo + err_mon == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/stress_vectors.txt
// words stall_at stall_len corrupt exp_err hold_echo, all hex
// stall_at and corrupt of ffff mean none, a word count of 0 ends the list
0010 ffff 0000 ffff 0 0
0008 ffff 0000 0003 1 0
000c 0004 0400 ffff 0 0
0006 ffff 0000 ffff 0 1
000a 0002 0400 0005 1 0
0005 ffff 0000 0000 1 0
0000 0000 0000 0000 0 0

//--- verilog.f
design/link_pkg.sv
design/stress_pkg.sv
design/baud_timer.sv
design/uart_rx.sv
design/uart_tx.sv
design/word_framer.sv
design/stress_ctrl.sv
design/stress_top.sv
bench/stress_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the stress tester testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --top-module stress_tb -f verilog.f -o stress_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/stress_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Finished with errors" "$log"; then
   exit 1
fi
exit 0
